//--- Bender.yml
package:
  name: spi_out

sources:
  - include_dirs:
      - common
    files:
      - common/spi_out_pkg.sv
      - async_fifo/async_fifo.sv
      - logic/wr_session_ctrl.sv
      - logic/spi_out_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/fpga_reader_model.sv
      - verification/tb_spi_out.sv

//--- async_fifo/async_fifo.sv
`timescale 1ns/1ps
`include "spi_out_settings.svh"

module async_fifo #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 4
) (
  input  logic              rst_n,
  // write side
  input  logic              wr_clk,
  input  logic              wr_en,
  input  logic [DATA_W-1:0] din,
  // read side
  input  logic              rd_clk,
  input  logic              rd_en,
  output logic [DATA_W-1:0] dout,
  output logic              empty,
  output logic              full,
  output logic              almost_full
);

  localparam int PTR_W = ADDR_W + 1; // extra wrap bit
  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  // write domain
  logic [PTR_W-1:0] wr_bin;
  logic [PTR_W-1:0] wr_bin_next;
  logic [PTR_W-1:0] wr_gray;
  logic [PTR_W-1:0] rd_gray_s1; // read pointer crossing
  logic [PTR_W-1:0] rd_gray_s2;
  logic [PTR_W-1:0] rd_bin_s;
  logic [PTR_W-1:0] wr_occ_next;
  logic             wr_fire;

  // read domain
  logic [PTR_W-1:0] rd_bin;
  logic [PTR_W-1:0] rd_bin_next;
  logic [PTR_W-1:0] rd_gray;
  logic [PTR_W-1:0] wr_gray_s1; // write pointer crossing
  logic [PTR_W-1:0] wr_gray_s2;
  logic             rd_fire;

  function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
    logic [PTR_W-1:0] b;
    b[PTR_W-1] = g[PTR_W-1];
    for (int i = PTR_W - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // ================================================
  // write domain
  // ================================================

  assign wr_fire     = wr_en & ~full;
  assign wr_bin_next = wr_bin + PTR_W'(wr_fire);

  // full when the pointers differ only in the two top gray bits
  assign full = (wr_gray == {~rd_gray_s2[PTR_W-1:PTR_W-2], rd_gray_s2[PTR_W-3:0]});

  assign rd_bin_s    = gray2bin(rd_gray_s2);
  assign wr_occ_next = wr_bin_next - rd_bin_s; // pessimistic, read side lags

  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_next;
      wr_gray <= bin2gray(wr_bin_next);
    end
  end

  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  // level reflects the occupancy after this edge's write
  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      almost_full <= 1'b0;
    end else begin
      almost_full <= (wr_occ_next >= PTR_W'(`SPI_OUT_ALMOST_FULL));
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_fire) begin
      mem[wr_bin[ADDR_W-1:0]] <= din;
    end
  end

  // ================================================
  // read domain
  // ================================================

  assign empty       = (rd_gray == wr_gray_s2);
  assign rd_fire     = rd_en & ~empty;
  assign rd_bin_next = rd_bin + PTR_W'(rd_fire);

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_next;
      rd_gray <= bin2gray(rd_bin_next);
    end
  end

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign dout = mem[rd_bin[ADDR_W-1:0]]; // head word falls through

  // ================================================
  // checks
  // ================================================

  // write side throttling must keep the producer out of a full FIFO
  a_no_write_full : assert property (
    @(posedge wr_clk) disable iff (!rst_n) wr_en |-> !full
  ) else $error("async_fifo: write while full");

  // the FPGA must not clock a word that has not crossed yet
  a_no_read_empty : assert property (
    @(posedge rd_clk) disable iff (!rst_n) rd_en |-> !empty
  ) else $error("async_fifo: read while empty");

endmodule

//--- common/spi_out_pkg.sv
`include "spi_out_settings.svh"

package spi_out_pkg;

  // ================================================
  // session FSM
  // ================================================

  typedef enum logic [2:0] {
    IDLE    = 3'd0, // waiting for config pulse
    CONFIG  = 3'd1, // config latched
    WAIT_CS = 3'd2, // request raised, header on the link
    WR_DATA = 3'd3, // FPGA draining the FIFO
    CLOSE   = 3'd4  // chip select back high
  } session_state_e;

  // ================================================
  // interface opcodes
  // ================================================

  // anything not listed falls back to the FLGOFM burst
  typedef enum logic [3:0] {
    IF_FLGOFM = 4'd1,
    IF_OFM    = 4'd2
  } if_code_e;

  // ================================================
  // config and header words
  // ================================================

  // config strobe payload, 12 bits
  typedef struct packed {
    logic [3:0]                  opcode;
    logic [`SPI_OUT_SCHED_W-1:0] sched;
  } cfg_cmd_t;

  // header seen by the FPGA while chip select is high
  typedef struct packed {
    logic [3:0]                                 opcode; // bits 31:28
    logic [`SPI_OUT_SCHED_W-1:0]                sched;  // bits 27:20
    logic [`SPI_OUT_DATA_W-4-`SPI_OUT_SCHED_W-1:0] zero;   // always zero
  } spi_header_t;

endpackage

//--- common/spi_out_settings.svh
`ifndef SPI_OUT_SETTINGS_SVH
`define SPI_OUT_SETTINGS_SVH

// ================================================
// link and datapath widths
// ================================================

// word width on the FPGA link and on the producer side
`define SPI_OUT_DATA_W 32

// schedule word carried in the header
`define SPI_OUT_SCHED_W 8

// accepted beat counter
`define SPI_OUT_CNT_W 20

// ================================================
// FIFO sizing
// ================================================

`define SPI_OUT_FIFO_AW 4 // depth 16

// write side occupancy that throttles the producer
`define SPI_OUT_ALMOST_FULL 14

// ================================================
// burst lengths in words
// ================================================

`define SPI_OUT_SIZE_FLGOFM 4
`define SPI_OUT_SIZE_OFM 20

`endif

//--- logic/spi_out_top.sv
`timescale 1ns/1ps
`include "spi_out_settings.svh"

module spi_out_top (
  input  logic                       clk_chip,
  input  logic                       reset_n_chip,
  // FPGA pins
  input  logic                       spi_sck,
  input  logic                       spi_cs_n,
  output logic [`SPI_OUT_DATA_W-1:0] spi_data,
  output logic                       config_req,
  // on-chip side
  input  logic                       cfg_pulse,
  input  spi_out_pkg::cfg_cmd_t      cfg_cmd,
  output logic                       config_ready,
  input  logic                       gb_valid,
  input  logic                       wr_req,
  input  logic [`SPI_OUT_DATA_W-1:0] wr_data,
  output logic                       wr_ready
);

  logic                       fifo_wr_en;
  logic [`SPI_OUT_DATA_W-1:0] fifo_din;
  logic [`SPI_OUT_DATA_W-1:0] fifo_dout;
  logic                       fifo_almost_full;

  wr_session_ctrl ctrl_inst (
    .clk_chip         (clk_chip),
    .reset_n_chip     (reset_n_chip),
    .spi_sck          (spi_sck),
    .spi_cs_n         (spi_cs_n),
    .config_req       (config_req),
    .spi_data         (spi_data),
    .cfg_pulse        (cfg_pulse),
    .cfg_cmd          (cfg_cmd),
    .config_ready     (config_ready),
    .gb_valid         (gb_valid),
    .wr_req           (wr_req),
    .wr_data          (wr_data),
    .wr_ready         (wr_ready),
    .fifo_almost_full (fifo_almost_full),
    .fifo_dout        (fifo_dout),
    .fifo_wr_en       (fifo_wr_en),
    .fifo_din         (fifo_din)
  );

  // read side runs on the FPGA clock, one pop per sck edge with cs low
  async_fifo #(
    .DATA_W (`SPI_OUT_DATA_W),
    .ADDR_W (`SPI_OUT_FIFO_AW)
  ) fifo_inst (
    .rst_n       (reset_n_chip),
    .wr_clk      (clk_chip),
    .wr_en       (fifo_wr_en),
    .din         (fifo_din),
    .rd_clk      (spi_sck),
    .rd_en       (~spi_cs_n),
    .dout        (fifo_dout),
    .empty       (),
    .full        (),
    .almost_full (fifo_almost_full)
  );

endmodule

//--- logic/wr_session_ctrl.sv
`timescale 1ns/1ps
`include "spi_out_settings.svh"

module wr_session_ctrl (
  input  logic                        clk_chip,
  input  logic                        reset_n_chip,
  // FPGA side
  input  logic                        spi_sck,
  input  logic                        spi_cs_n,
  output logic                        config_req,
  output logic [`SPI_OUT_DATA_W-1:0]  spi_data,
  // on-chip controller and producer
  input  logic                        cfg_pulse,
  input  spi_out_pkg::cfg_cmd_t       cfg_cmd,
  output logic                        config_ready,
  input  logic                        gb_valid,
  input  logic                        wr_req,
  input  logic [`SPI_OUT_DATA_W-1:0]  wr_data,
  output logic                        wr_ready,
  // FIFO
  input  logic                        fifo_almost_full,
  input  logic [`SPI_OUT_DATA_W-1:0]  fifo_dout,
  output logic                        fifo_wr_en,
  output logic [`SPI_OUT_DATA_W-1:0]  fifo_din
);

  localparam int CNT_W = `SPI_OUT_CNT_W;

  spi_out_pkg::session_state_e state;
  spi_out_pkg::session_state_e state_next;
  spi_out_pkg::cfg_cmd_t       cfg_latch;
  spi_out_pkg::spi_header_t    header;

  logic [CNT_W-1:0] burst_size;
  logic [CNT_W-1:0] beat_cnt;
  logic             done;
  logic             accept;
  logic             last_beat;

  logic       cs_n_d;     // cs delayed by one sck edge
  logic [2:0] cs_n_sync;  // [2] is the synchronized copy
  logic [2:0] cs_n_d_sync;

  // ================================================
  // config latch and burst size
  // ================================================

  always_ff @(posedge clk_chip or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      cfg_latch  <= '0;
      burst_size <= '0;
    end else if (cfg_pulse) begin
      cfg_latch <= cfg_cmd;
      case (spi_out_pkg::if_code_e'(cfg_cmd.opcode))
        spi_out_pkg::IF_FLGOFM: burst_size <= CNT_W'(`SPI_OUT_SIZE_FLGOFM);
        spi_out_pkg::IF_OFM:    burst_size <= CNT_W'(`SPI_OUT_SIZE_OFM);
        default:                burst_size <= CNT_W'(`SPI_OUT_SIZE_FLGOFM);
      endcase
    end
  end

  // ================================================
  // session FSM
  // ================================================

  always_comb begin
    state_next = state;
    case (state)
      spi_out_pkg::IDLE:    if (cfg_pulse) state_next = spi_out_pkg::CONFIG;
      spi_out_pkg::CONFIG:  state_next = spi_out_pkg::WAIT_CS;
      spi_out_pkg::WAIT_CS: if (!cs_n_sync[2]) state_next = spi_out_pkg::WR_DATA;
      // both copies high, so the last sck edge has passed
      spi_out_pkg::WR_DATA: if (cs_n_sync[2] && cs_n_d_sync[2]) state_next = spi_out_pkg::CLOSE;
      spi_out_pkg::CLOSE:   state_next = spi_out_pkg::IDLE;
      default:              state_next = spi_out_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_chip or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      state <= spi_out_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk_chip or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      config_req <= 1'b0;
    end else if (state == spi_out_pkg::CONFIG) begin
      config_req <= 1'b1; // rises leaving CONFIG
    end else if (state == spi_out_pkg::WR_DATA) begin
      config_req <= 1'b0;
    end
  end

  assign config_ready = (state == spi_out_pkg::IDLE);

  // ================================================
  // producer window and beat count
  // ================================================

  assign wr_ready  = (state != spi_out_pkg::IDLE) & ~fifo_almost_full & gb_valid & ~done;
  assign accept    = wr_req & wr_ready;
  assign last_beat = (beat_cnt == burst_size - CNT_W'(1));

  always_ff @(posedge clk_chip or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      beat_cnt <= '0;
      done     <= 1'b0;
    end else if (state == spi_out_pkg::IDLE) begin
      beat_cnt <= '0;
      done     <= 1'b0;
    end else if (accept) begin
      beat_cnt <= beat_cnt + CNT_W'(1);
      if (last_beat) begin
        done <= 1'b1; // closes the window next cycle
      end
    end
  end

  assign fifo_wr_en = accept;
  assign fifo_din   = wr_data;

  // ================================================
  // chip select crossing
  // ================================================

  always_ff @(posedge spi_sck or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      cs_n_d <= 1'b1;
    end else begin
      cs_n_d <= spi_cs_n;
    end
  end

  always_ff @(posedge clk_chip or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      cs_n_sync   <= 3'b111;
      cs_n_d_sync <= 3'b111;
    end else begin
      cs_n_sync   <= {cs_n_sync[1:0], spi_cs_n};
      cs_n_d_sync <= {cs_n_d_sync[1:0], cs_n_d};
    end
  end

  // header while cs and its delayed copy are high, else the FIFO head
  always_comb begin
    header        = '0;
    header.opcode = cfg_latch.opcode;
    header.sched  = cfg_latch.sched;
  end

  assign spi_data = (spi_cs_n && cs_n_d) ? header : fifo_dout;

  // ================================================
  // checks
  // ================================================

  a_cfg_in_idle : assert property (
    @(posedge clk_chip) disable iff (!reset_n_chip) cfg_pulse |-> state == spi_out_pkg::IDLE
  ) else $error("wr_session_ctrl: config pulse outside IDLE");

  // every accepted beat must still lie inside the burst
  a_no_beat_after_done : assert property (
    @(posedge clk_chip) disable iff (!reset_n_chip) fifo_wr_en |-> beat_cnt < burst_size
  ) else $error("wr_session_ctrl: beat accepted after burst end");

endmodule

//--- sim.f
+incdir+common
common/spi_out_pkg.sv
async_fifo/async_fifo.sv
logic/wr_session_ctrl.sv
logic/spi_out_top.sv
verification/fpga_reader_model.sv
verification/tb_spi_out.sv

//--- verification/fpga_reader_model.sv
`timescale 1ns/1ps
`include "spi_out_settings.svh"

module fpga_reader_model #(
  parameter int SCK_HALF  = 100,
  parameter int SCK_PHASE = 37
) (
  output logic                       spi_sck,
  output logic                       spi_cs_n,
  input  logic [`SPI_OUT_DATA_W-1:0] spi_data,
  input  logic                       config_req,
  // testbench control
  input  logic                       read_go,
  input  logic [7:0]                 read_len,
  output logic                       read_done,
  output logic [`SPI_OUT_DATA_W-1:0] rx_header,
  output logic [`SPI_OUT_DATA_W-1:0] rx_word,
  output logic [15:0]                rx_count
);

  localparam int SETTLE = 5; // sample point after the falling sck edge

  // ================================================
  // serial clock
  // ================================================

  // offset keeps sck edges away from clk_chip edges
  initial begin
    spi_sck = 1'b0;
    #(SCK_PHASE);
    forever #(SCK_HALF) spi_sck = ~spi_sck;
  end

  // ================================================
  // session
  // ================================================

  initial begin
    int i;
    spi_cs_n  = 1'b1;
    read_done = 1'b0;
    rx_header = '0;
    rx_word   = '0;
    rx_count  = '0;
    forever begin
      wait (read_go && config_req);
      @(negedge spi_sck);
      #(SETTLE);
      rx_header = spi_data; // cs and delayed cs both high
      repeat (3) @(posedge spi_sck); // write pointer crossing
      @(negedge spi_sck);
      spi_cs_n = 1'b0;
      for (i = 0; i < read_len; i++) begin
        #(SETTLE);
        rx_word  = spi_data; // head word before its pop
        rx_count = rx_count + 16'd1;
        @(negedge spi_sck); // pop on the rising edge in between
      end
      spi_cs_n  = 1'b1;
      read_done = 1'b1;
      wait (!read_go);
      read_done = 1'b0;
    end
  end

endmodule

//--- verification/tb_spi_out.sv
`timescale 1ns/1ps
`include "spi_out_settings.svh"

module tb_spi_out;

  localparam int CLK_HALF   = 20;
  localparam int SCK_PERIOD = 200;
  localparam int N_TESTS    = 4;
  localparam int HOLD_CYC   = 3; // wr_req kept high after the burst
  localparam int AF_LEVEL   = `SPI_OUT_ALMOST_FULL;

  typedef struct packed {
    logic [3:0] opcode;
    logic [7:0] sched;
    logic [7:0] gap_mask; // gb_valid per cycle, bit 0 first
    logic [7:0] exp_len;  // burst size in words
  } stim_t;

  logic                       clk_chip;
  logic                       reset_n_chip;
  logic                       spi_sck;
  logic                       spi_cs_n;
  logic                       cfg_pulse;
  spi_out_pkg::cfg_cmd_t      cfg_cmd;
  logic                       gb_valid;
  logic                       wr_req;
  logic [`SPI_OUT_DATA_W-1:0] wr_data;
  logic [`SPI_OUT_DATA_W-1:0] spi_data;
  logic                       config_req;
  logic                       config_ready;
  logic                       wr_ready;

  logic                       read_go;
  logic [7:0]                 read_len;
  logic                       read_done;
  logic [`SPI_OUT_DATA_W-1:0] rx_header;
  logic [`SPI_OUT_DATA_W-1:0] rx_word;
  logic [15:0]                rx_count;

  stim_t       stim_tab [N_TESTS];
  logic [31:0] exp_q [$];
  logic [31:0] rx_q [$];
  int          err_cnt = 0;
  int          check_cnt = 0;

  spi_out_top spi_out_top_inst (
    .clk_chip     (clk_chip),
    .reset_n_chip (reset_n_chip),
    .spi_sck      (spi_sck),
    .spi_cs_n     (spi_cs_n),
    .spi_data     (spi_data),
    .config_req   (config_req),
    .cfg_pulse    (cfg_pulse),
    .cfg_cmd      (cfg_cmd),
    .config_ready (config_ready),
    .gb_valid     (gb_valid),
    .wr_req       (wr_req),
    .wr_data      (wr_data),
    .wr_ready     (wr_ready)
  );

  fpga_reader_model reader_inst (
    .spi_sck    (spi_sck),
    .spi_cs_n   (spi_cs_n),
    .spi_data   (spi_data),
    .config_req (config_req),
    .read_go    (read_go),
    .read_len   (read_len),
    .read_done  (read_done),
    .rx_header  (rx_header),
    .rx_word    (rx_word),
    .rx_count   (rx_count)
  );

  always #(CLK_HALF) clk_chip = ~clk_chip;

  // every new word from the reader
  always @(rx_count) begin
    if (rx_count != 16'd0) rx_q.push_back(rx_word);
  end

  task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("FAIL %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // ================================================
  // stimulus table and test loop
  // ================================================

  initial begin
    int          t;
    int          i;
    int          accepted;
    int          hold;
    int          cyc;
    int          start_cnt;
    int          errs_before;
    logic        af_seen;
    logic [31:0] word;
    logic [31:0] exp_header;
    logic [31:0] seed;
    stim_t       s;

    seed = 32'd93;
    seed = $urandom(seed);
    stim_tab[0] = {4'd1, 8'h5A, 8'hFF, 8'd4};
    stim_tab[1] = {4'd2, 8'hC3, 8'hFF, 8'd20};
    stim_tab[2] = {4'd2, 8'h3C, 8'b1011_0110, 8'd20}; // gb_valid gaps
    stim_tab[3] = {4'd7, 8'h81, 8'b0110_1101, 8'd4};  // unknown opcode

    clk_chip     = 1'b0;
    reset_n_chip = 1'b0;
    cfg_pulse    = 1'b0;
    cfg_cmd      = '0;
    gb_valid     = 1'b0;
    wr_req       = 1'b0;
    wr_data      = '0;
    read_go      = 1'b0;
    read_len     = '0;
    repeat (3) @(posedge clk_chip);
    @(negedge clk_chip);
    reset_n_chip = 1'b1;
    #1;
    expect_eq(config_ready, 1, "config_ready after reset");
    expect_eq(config_req, 0, "config_req after reset");
    expect_eq(wr_ready, 0, "wr_ready after reset");
    expect_eq(spi_data, 32'h0, "header after reset");
    $display("reset check: %s", (err_cnt == 0) ? "ok" : "errors");

    for (t = 0; t < N_TESTS; t++) begin
      s           = stim_tab[t];
      errs_before = err_cnt;
      exp_header  = {s.opcode, s.sched, 20'h0};
      start_cnt   = (s.exp_len < AF_LEVEL) ? s.exp_len : AF_LEVEL;
      word        = $urandom;

      @(negedge clk_chip);
      expect_eq(config_ready, 1, "config_ready before strobe");
      cfg_pulse      = 1'b1;
      cfg_cmd.opcode = s.opcode;
      cfg_cmd.sched  = s.sched;
      @(negedge clk_chip);
      cfg_pulse = 1'b0;
      #1;
      expect_eq(config_ready, 0, "config_ready one cycle after strobe");
      expect_eq(config_req, 0, "config_req in CONFIG");
      @(negedge clk_chip);
      #1;
      expect_eq(config_req, 1, "config_req after CONFIG");
      expect_eq(spi_data, exp_header, "header on spi_data");

      // producer, one word per accepted beat
      read_len = s.exp_len;
      accepted = 0;
      hold     = 0;
      cyc      = 0;
      af_seen  = 1'b0;
      while (accepted < s.exp_len || hold < HOLD_CYC) begin
        @(negedge clk_chip);
        gb_valid = s.gap_mask[cyc % 8];
        cyc++;
        wr_req  = 1'b1;
        wr_data = word;
        #1;
        if (!gb_valid) expect_eq(wr_ready, 0, "wr_ready with gb_valid low");
        if (accepted == s.exp_len) begin
          expect_eq(wr_ready, 0, "wr_ready after burst end");
          hold++;
        end else begin
          if (accepted == AF_LEVEL && !af_seen) begin
            expect_eq(wr_ready, 0, "wr_ready at almost full");
            af_seen = 1'b1;
          end
          if (wr_ready) begin
            exp_q.push_back(word);
            word = word + 32'd1;
            accepted++;
            if (accepted >= start_cnt) read_go = 1'b1; // FIFO holds enough
          end
        end
      end
      @(negedge clk_chip);
      wr_req   = 1'b0;
      gb_valid = 1'b0;

      while (!read_done) @(negedge clk_chip);
      while (!config_ready) @(negedge clk_chip); // session closed
      #1;
      expect_eq(config_req, 0, "config_req after close");
      expect_eq(rx_header, exp_header, "header seen by reader");
      for (i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
        expect_eq(rx_q[i], exp_q[i], "word order");
      end
      read_go = 1'b0;
      while (read_done) @(negedge clk_chip);
      exp_q.delete();
      rx_q.delete();
      $display("test %0d opcode %0d len %0d: %s", t, s.opcode, s.exp_len,
               (err_cnt == errs_before) ? "ok" : "errors");
    end

    $display("tests: %0d, checks: %0d, errors: %0d", N_TESTS, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // ================================================
  // watchdog
  // ================================================

  initial begin
    int limit_ns;
    #1;
    limit_ns = N_TESTS * 2000; // 2 us per entry
    for (int i = 0; i < N_TESTS; i++) begin
      limit_ns += stim_tab[i].exp_len * 6 * SCK_PERIOD;
    end
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    $display("sim failed");
    $finish;
  end

endmodule
